/* src/fp_cmp_pkg.sv */
// Shared widths, opcodes, register map and bus structs for the float compare engine
package fp_cmp_pkg;

	// ************************************************************************
	// Float format
	// ************************************************************************
	localparam int FP_W  = 32;	// Single precision only
	localparam int EXP_W = 8;
	localparam int MAN_W = 23;

	typedef logic [FP_W-1:0]  fp_word_t;
	typedef logic [EXP_W-1:0] fp_exp_t;
	typedef logic [MAN_W-1:0] fp_man_t;
	typedef logic [2:0]       cmp_op_t;	// Compare predicate select

	localparam cmp_op_t OP_LT = 3'd0;
	localparam cmp_op_t OP_GE = 3'd1;
	localparam cmp_op_t OP_LE = 3'd2;
	localparam cmp_op_t OP_GT = 3'd3;
	localparam cmp_op_t OP_EQ = 3'd4;
	localparam cmp_op_t OP_NE = 3'd5;
	localparam cmp_op_t OP_UN = 3'd6;	// Unordered
	localparam cmp_op_t OP_OR = 3'd7;	// Ordered

	// ************************************************************************
	// Request queue and register map
	// ************************************************************************
	localparam int FIFO_DEPTH = 4;

	typedef logic [2:0]  fifo_cnt_t;	// Holds 0 to FIFO_DEPTH
	typedef logic [4:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;

	localparam axil_addr_t ADDR_A      = 5'h00;	// Operand A, rw
	localparam axil_addr_t ADDR_B      = 5'h04;	// Operand B, rw
	localparam axil_addr_t ADDR_CMD    = 5'h08;	// Write pushes a request
	localparam axil_addr_t ADDR_RESULT = 5'h0C;	// Read releases the result
	localparam axil_addr_t ADDR_STATUS = 5'h10;	// FIFO count and full

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		cmp_op_t  op;
		fp_word_t a;
		fp_word_t b;
	} cmp_req_t;	// 67 bits

	typedef struct packed {
		logic o;	// Predicate outcome
		logic nanx;	// Invalid operation
	} cmp_rsp_t;

	typedef struct packed {
		axil_addr_t awaddr;
		axil_data_t wdata;
	} axil_wr_t;

	typedef struct packed {
		axil_data_t rdata;
		logic [1:0] rresp;
	} axil_rd_t;

	typedef enum logic {
		ST_IDLE,	// Ready for a new transfer
		ST_RESP	// Response waiting for the master
	} axil_state_t;

endpackage

/* src/fp_decomp.sv */
// Float field splitter that also flags zero and NaN operands
`timescale 1ns/1ns

module fp_decomp (
	input  fp_cmp_pkg::fp_word_t i,
	output logic                 sgn,
	output fp_cmp_pkg::fp_exp_t  exp,
	output fp_cmp_pkg::fp_man_t  man,
	output logic                 vz,
	output logic                 nan
);

	// Field extraction
	assign sgn = i[fp_cmp_pkg::FP_W-1];	// Top bit is the sign
	assign exp = i[fp_cmp_pkg::FP_W-2 -: fp_cmp_pkg::EXP_W];	// Biased exponent
	assign man = i[fp_cmp_pkg::MAN_W-1:0];	// Fraction without hidden bit

	// Classification
	assign vz  = (exp == '0) && (man == '0);	// Either zero, sign ignored
	assign nan = (&exp) && (|man);	// Max exponent, nonzero fraction

endmodule

/* src/fp_cmp_unit.sv */
// Combinational single precision compare under eight predicates with invalid flag
`timescale 1ns/1ns

module fp_cmp_unit (
	input  fp_cmp_pkg::cmp_op_t  op,
	input  fp_cmp_pkg::fp_word_t a,
	input  fp_cmp_pkg::fp_word_t b,
	output logic                 o,
	output logic                 nanx
);

	logic                sa, sb;	// Signs
	fp_cmp_pkg::fp_exp_t xa, xb;	// Exponents
	fp_cmp_pkg::fp_man_t ma, mb;	// Mantissas
	logic                az, bz;	// Zero flags
	logic                nan_a, nan_b;
	logic [fp_cmp_pkg::FP_W-2:0] mag_a, mag_b;	// Exponent and mantissa magnitude
	logic                unordered;
	logic                eq;
	logic                lt;
	logic                lt_mag;

	fp_decomp fp_decomp_a_inst (.i(a), .sgn(sa), .exp(xa), .man(ma), .vz(az), .nan(nan_a));
	fp_decomp fp_decomp_b_inst (.i(b), .sgn(sb), .exp(xb), .man(mb), .vz(bz), .nan(nan_b));

	assign unordered = nan_a | nan_b;	// Any NaN breaks ordering
	assign eq        = (az & bz) | (a == b);	// +0 and -0 match too

	// Two negatives flip the magnitude order
	assign mag_a  = sa ? ~{xa, ma} : {xa, ma};
	assign mag_b  = sb ? ~{xb, mb} : {xb, mb};
	assign lt_mag = mag_a < mag_b;

	// Sign decides first, unless both are zeros
	assign lt = (sa ^ sb) ? (sa & ~(az & bz)) : lt_mag;

	always_comb begin
		o = 1'b0;
		case (op)
			fp_cmp_pkg::OP_LT: o = lt;
			fp_cmp_pkg::OP_GE: o = ~lt;
			fp_cmp_pkg::OP_LE: o = lt | eq;
			fp_cmp_pkg::OP_GT: o = ~(lt | eq);
			fp_cmp_pkg::OP_EQ: o = eq;
			fp_cmp_pkg::OP_NE: o = ~eq;
			fp_cmp_pkg::OP_UN: o = unordered;
			fp_cmp_pkg::OP_OR: o = ~unordered;
			default:           o = 1'b0;
		endcase
	end

	// Only the ordering queries tolerate NaN quietly
	assign nanx = unordered && (op != fp_cmp_pkg::OP_OR) && (op != fp_cmp_pkg::OP_UN);

endmodule

/* src/cmp_axil_regs.sv */
// AXI4-Lite register front end that queues compare requests and returns results
`timescale 1ns/1ns

module cmp_axil_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   awvalid,
	output logic                   awready,
	input  fp_cmp_pkg::axil_addr_t awaddr,
	input  logic                   wvalid,
	output logic                   wready,
	input  fp_cmp_pkg::axil_data_t wdata,
	output logic                   bvalid,
	input  logic                   bready,
	output logic [1:0]             bresp,
	input  logic                   arvalid,
	output logic                   arready,
	input  fp_cmp_pkg::axil_addr_t araddr,
	output logic                   rvalid,
	input  logic                   rready,
	output fp_cmp_pkg::axil_data_t rdata,
	output logic [1:0]             rresp,
	output logic                   req_push,
	output fp_cmp_pkg::cmp_req_t   req,
	input  logic                   fifo_full,
	input  fp_cmp_pkg::fifo_cnt_t  fifo_cnt,
	input  logic                   rsp_valid,
	input  fp_cmp_pkg::cmp_rsp_t   rsp,
	output logic                   rsp_release
);

	fp_cmp_pkg::axil_state_t wr_state, rd_state;
	fp_cmp_pkg::axil_wr_t    wr_in;	// Address and data of the current write
	fp_cmp_pkg::axil_rd_t    rd_next, rd_q;	// Read reply, next and held
	fp_cmp_pkg::fp_word_t    op_a, op_b;	// Operand registers
	logic [1:0]              bresp_next, bresp_q;
	logic                    wr_hs, rd_hs;

	// ************************************************************************
	// Write channel
	// ************************************************************************
	assign wr_in   = '{awaddr: awaddr, wdata: wdata};
	assign wr_hs   = (wr_state == fp_cmp_pkg::ST_IDLE) && awvalid && wvalid;
	assign awready = wr_hs;	// Both channels accepted together
	assign wready  = wr_hs;
	assign bvalid  = (wr_state == fp_cmp_pkg::ST_RESP);
	assign bresp   = bresp_q;

	// Request is built from the live command word
	assign req      = '{op: fp_cmp_pkg::cmp_op_t'(wr_in.wdata[2:0]), a: op_a, b: op_b};
	assign req_push = wr_hs && (wr_in.awaddr == fp_cmp_pkg::ADDR_CMD) && !fifo_full;

	always_comb begin
		case (wr_in.awaddr)
			fp_cmp_pkg::ADDR_A,
			fp_cmp_pkg::ADDR_B:   bresp_next = fp_cmp_pkg::RESP_OKAY;
			fp_cmp_pkg::ADDR_CMD: bresp_next = fifo_full ? fp_cmp_pkg::RESP_SLVERR
			                                             : fp_cmp_pkg::RESP_OKAY;
			default:              bresp_next = fp_cmp_pkg::RESP_SLVERR;	// RO or unmapped
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_state <= fp_cmp_pkg::ST_IDLE;
			op_a     <= '0;
			op_b     <= '0;
		end else begin
			case (wr_state)
				fp_cmp_pkg::ST_IDLE: if (wr_hs) begin
					wr_state <= fp_cmp_pkg::ST_RESP;
					if (wr_in.awaddr == fp_cmp_pkg::ADDR_A) op_a <= wr_in.wdata;
					if (wr_in.awaddr == fp_cmp_pkg::ADDR_B) op_b <= wr_in.wdata;
				end
				fp_cmp_pkg::ST_RESP: if (bready) wr_state <= fp_cmp_pkg::ST_IDLE;
				default: wr_state <= fp_cmp_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) bresp_q <= bresp_next;	// Held until bready
	end

	// ************************************************************************
	// Read channel
	// ************************************************************************
	assign arready     = (rd_state == fp_cmp_pkg::ST_IDLE);
	assign rd_hs       = arready && arvalid;
	assign rvalid      = (rd_state == fp_cmp_pkg::ST_RESP);
	assign rdata       = rd_q.rdata;
	assign rresp       = rd_q.rresp;
	assign rsp_release = rd_hs && (araddr == fp_cmp_pkg::ADDR_RESULT) && rsp_valid;

	always_comb begin
		rd_next = '{rdata: '0, rresp: fp_cmp_pkg::RESP_OKAY};
		case (araddr)
			fp_cmp_pkg::ADDR_A:      rd_next.rdata = op_a;
			fp_cmp_pkg::ADDR_B:      rd_next.rdata = op_b;
			fp_cmp_pkg::ADDR_RESULT: if (rsp_valid) begin
				rd_next.rdata = fp_cmp_pkg::axil_data_t'({rsp.nanx, rsp.o, 1'b1});
			end
			fp_cmp_pkg::ADDR_STATUS: begin
				rd_next.rdata = fp_cmp_pkg::axil_data_t'({fifo_full, fifo_cnt});
			end
			default: rd_next.rresp = fp_cmp_pkg::RESP_SLVERR;	// CMD is write only
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state <= fp_cmp_pkg::ST_IDLE;
		end else begin
			case (rd_state)
				fp_cmp_pkg::ST_IDLE: if (rd_hs) rd_state <= fp_cmp_pkg::ST_RESP;
				fp_cmp_pkg::ST_RESP: if (rready) rd_state <= fp_cmp_pkg::ST_IDLE;
				default: rd_state <= fp_cmp_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs) rd_q <= rd_next;	// Stable while rvalid
	end

endmodule

/* src/cmp_req_fifo.sv */
// Circular request FIFO with fill count, full flag and head valid
`timescale 1ns/1ns

module cmp_req_fifo #(
	parameter int DEPTH = fp_cmp_pkg::FIFO_DEPTH	// Power of two
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push,
	input  fp_cmp_pkg::cmp_req_t  din,
	output logic                  full,
	output fp_cmp_pkg::fifo_cnt_t cnt,
	output logic                  valid,
	input  logic                  pop,
	output fp_cmp_pkg::cmp_req_t  dout
);

	fp_cmp_pkg::cmp_req_t         mem [DEPTH];	// Entry storage
	logic [$clog2(DEPTH)-1:0]     wr_ptr, rd_ptr;	// Wrap naturally
	fp_cmp_pkg::fifo_cnt_t        count;
	logic                         do_push, do_pop;

	assign full    = (count == fp_cmp_pkg::fifo_cnt_t'(DEPTH));
	assign valid   = (count != '0);
	assign cnt     = count;
	assign dout    = mem[rd_ptr];	// Head visible one cycle after push
	assign do_push = push && !full;	// Overflow guarded here as well
	assign do_pop  = pop && valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle or push with pop
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= din;
	end

endmodule

/* src/cmp_exec.sv */
// Compare execution stage that pops requests and holds one result for the host
`timescale 1ns/1ns

module cmp_exec (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req_valid,
	input  fp_cmp_pkg::cmp_req_t req,
	output logic                 req_pop,
	output logic                 rsp_valid,
	output fp_cmp_pkg::cmp_rsp_t rsp,
	input  logic                 rsp_release
);

	fp_cmp_pkg::cmp_rsp_t cmp_now;	// Outcome for the FIFO head

	fp_cmp_unit fp_cmp_unit_inst (
		.op   (req.op),
		.a    (req.a),
		.b    (req.b),
		.o    (cmp_now.o),
		.nanx (cmp_now.nanx)
	);

	// Slot empty or emptied this cycle
	assign req_pop = req_valid && (!rsp_valid || rsp_release);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else if (req_pop) begin
			rsp_valid <= 1'b1;	// Refill wins over release
		end else if (rsp_release) begin
			rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_pop) rsp <= cmp_now;	// Capture result
	end

endmodule

/* src/fp_cmp_top.sv */
// Top level of the AXI4-Lite float compare engine
`timescale 1ns/1ns

module fp_cmp_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   awvalid,
	output logic                   awready,
	input  fp_cmp_pkg::axil_addr_t awaddr,
	input  logic                   wvalid,
	output logic                   wready,
	input  fp_cmp_pkg::axil_data_t wdata,
	output logic                   bvalid,
	input  logic                   bready,
	output logic [1:0]             bresp,
	input  logic                   arvalid,
	output logic                   arready,
	input  fp_cmp_pkg::axil_addr_t araddr,
	output logic                   rvalid,
	input  logic                   rready,
	output fp_cmp_pkg::axil_data_t rdata,
	output logic [1:0]             rresp
);

	logic                  req_push, fifo_full, fifo_valid, fifo_pop;
	fp_cmp_pkg::cmp_req_t  push_req, head_req;	// Into and out of the queue
	fp_cmp_pkg::fifo_cnt_t fifo_cnt;
	logic                  rsp_valid, rsp_release;
	fp_cmp_pkg::cmp_rsp_t  rsp;

	cmp_axil_regs cmp_axil_regs_inst (
		.clk, .rst_n,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.req_push (req_push), .req (push_req),
		.fifo_full (fifo_full), .fifo_cnt (fifo_cnt),
		.rsp_valid (rsp_valid), .rsp (rsp), .rsp_release (rsp_release)
	);

	cmp_req_fifo cmp_req_fifo_inst (
		.clk, .rst_n,
		.push (req_push), .din (push_req), .full (fifo_full), .cnt (fifo_cnt),
		.valid (fifo_valid), .pop (fifo_pop), .dout (head_req)
	);

	cmp_exec cmp_exec_inst (
		.clk, .rst_n,
		.req_valid (fifo_valid), .req (head_req), .req_pop (fifo_pop),
		.rsp_valid (rsp_valid), .rsp (rsp), .rsp_release (rsp_release)
	);

endmodule

/* testbench/fp_cmp_props.sv */
// AXI4-Lite response channel rules checked on the register front end
`timescale 1ns/1ns

module fp_cmp_props (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   bvalid,
	input logic                   bready,
	input logic [1:0]             bresp,
	input logic                   rvalid,
	input logic                   rready,
	input fp_cmp_pkg::axil_data_t rdata,
	input logic [1:0]             rresp
);

	int unsigned fail_count = 0;	// Failed assertions so far

	// Both response channels idle once reset is seen
	rst_quiet: assert property (@(posedge clk) !rst_n |=> !bvalid && !rvalid)
		else begin
			$error("bvalid or rvalid high while reset is applied");
			fail_count++;
		end

	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))	// Held until accepted
		else begin
			$error("write response dropped or changed before bready");
			fail_count++;
		end

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("read response dropped or changed before rready");
			fail_count++;
		end

endmodule

bind cmp_axil_regs fp_cmp_props fp_cmp_props_inst (.*);

/* testbench/fp_cmp_tb.sv */
// Testbench for the AXI4-Lite float compare engine with directed and random compares
`timescale 1ns/1ns

module fp_cmp_tb;

	localparam int CLK_PERIOD = 100;
	localparam int TEST_LEN   = 5 + 40 + 16 + 40 + 13 + 2;	// Accesses and compares per test
	localparam int POLL_MAX   = 20;	// RESULT polls before giving up

	logic                   clk;
	logic                   rst_n;
	logic                   awvalid, awready, wvalid, wready;
	logic                   bvalid, bready, arvalid, arready, rvalid, rready;
	fp_cmp_pkg::axil_addr_t awaddr, araddr;
	fp_cmp_pkg::axil_data_t wdata, rdata;
	logic [1:0]             bresp, rresp;
	logic [31:0]            lfsr;	// Random state
	int                     n_pass, n_fail;

	fp_cmp_top fp_cmp_top_inst (.*);

	always #(CLK_PERIOD/2) clk = ~clk;

	// ************************************************************************
	// Helpers: random bits, reference model, checking
	// ************************************************************************
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);	// Galois step
			v = {v[30:0], lfsr[0]};	// One bit per step
		end
		return v;
	endfunction

	function automatic logic is_nan(input fp_cmp_pkg::fp_word_t f);
		return (f[30:23] == 8'hff) && (f[22:0] != '0);	// Max exponent, nonzero fraction
	endfunction

	// Returns {result, nanx}
	function automatic logic [1:0] model_cmp(input fp_cmp_pkg::cmp_op_t op,
			input fp_cmp_pkg::fp_word_t a, input fp_cmp_pkg::fp_word_t b);
		longint ka, kb;
		logic   un, lt, eq, o;
		un = is_nan(a) || is_nan(b);
		ka = a[31] ? -longint'(a[30:0]) : longint'(a[30:0]);	// Place on a number line
		kb = b[31] ? -longint'(b[30:0]) : longint'(b[30:0]);
		lt = ka < kb;
		eq = ka == kb;	// Both zeros land on 0
		case (op)
			fp_cmp_pkg::OP_LT: o = lt;
			fp_cmp_pkg::OP_GE: o = !lt;
			fp_cmp_pkg::OP_LE: o = lt || eq;
			fp_cmp_pkg::OP_GT: o = !lt && !eq;
			fp_cmp_pkg::OP_EQ: o = eq;
			fp_cmp_pkg::OP_NE: o = !eq;
			fp_cmp_pkg::OP_UN: o = un;
			default:           o = !un;	// OR
		endcase
		return {o, un && (op != fp_cmp_pkg::OP_UN) && (op != fp_cmp_pkg::OP_OR)};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected === actual) begin
			n_pass++;
		end else begin
			n_fail++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic finish_line(input string name, input int mark);
		$display("test %-14s %s (%0d failed checks)", name,
			(n_fail == mark) ? "ok" : "errors", n_fail - mark);
	endtask

	// ************************************************************************
	// Bus tasks, entered and left 1 ns after a rising edge
	// ************************************************************************
	task automatic axil_write(input fp_cmp_pkg::axil_addr_t addr,
			input fp_cmp_pkg::axil_data_t data, output logic [1:0] resp);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clk);
		while (!(awready && wready)) @(negedge clk);	// Handshake on the coming edge
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		@(negedge clk);
		while (!bvalid) @(negedge clk);
		@(posedge clk);	// Response left waiting for one edge
		#1;
		bready = 1'b1;
		@(negedge clk);
		resp = bresp;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axil_read(input fp_cmp_pkg::axil_addr_t addr,
			output fp_cmp_pkg::axil_data_t data, output logic [1:0] resp);
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid) @(negedge clk);
		@(posedge clk);	// Read data left waiting for one edge
		#1;
		rready = 1'b1;
		@(negedge clk);	// Sampled mid cycle
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic run_cmp(input fp_cmp_pkg::cmp_op_t op, input fp_cmp_pkg::fp_word_t a,
			input fp_cmp_pkg::fp_word_t b, output logic [31:0] result);
		logic [1:0] resp;
		int         polls;
		axil_write(fp_cmp_pkg::ADDR_A, a, resp);
		check("write A resp", fp_cmp_pkg::RESP_OKAY, resp);
		axil_write(fp_cmp_pkg::ADDR_B, b, resp);
		check("write B resp", fp_cmp_pkg::RESP_OKAY, resp);
		axil_write(fp_cmp_pkg::ADDR_CMD, 32'(op), resp);
		check("write CMD resp", fp_cmp_pkg::RESP_OKAY, resp);
		polls  = 0;
		result = '0;
		while (!result[0] && polls < POLL_MAX) begin
			axil_read(fp_cmp_pkg::ADDR_RESULT, result, resp);	// Bit 0 is result valid
			polls++;
		end
		if (!result[0]) begin
			n_fail++;
			$display("ERROR: no valid result after %0d reads of RESULT", POLL_MAX);
		end
	endtask

	task automatic cmp_and_check(input string name, input fp_cmp_pkg::cmp_op_t op,
			input fp_cmp_pkg::fp_word_t a, input fp_cmp_pkg::fp_word_t b);
		logic [31:0] result;
		logic [1:0]  expected;
		expected = model_cmp(op, a, b);
		run_cmp(op, a, b, result);
		check($sformatf("%s op%0d nanx", name, op), expected[0], result[2]);
		// Ordering predicates on NaN only define the flag
		if (!(is_nan(a) || is_nan(b)) || op == fp_cmp_pkg::OP_UN || op == fp_cmp_pkg::OP_OR)
			check($sformatf("%s op%0d result", name, op), expected[1], result[1]);
	endtask

	// ************************************************************************
	// Directed tests
	// ************************************************************************
	task automatic test_reset();
		fp_cmp_pkg::axil_data_t data;
		logic [1:0]             resp;
		axil_read(fp_cmp_pkg::ADDR_RESULT, data, resp);
		check("reset RESULT valid", 0, data[0]);
		check("reset RESULT resp", fp_cmp_pkg::RESP_OKAY, resp);
		axil_read(fp_cmp_pkg::ADDR_STATUS, data, resp);
		check("reset STATUS", 0, data);	// Empty and not full
		axil_read(fp_cmp_pkg::ADDR_A, data, resp);
		check("reset A", 0, data);
		axil_read(fp_cmp_pkg::ADDR_B, data, resp);
		check("reset B", 0, data);
	endtask

	task automatic test_ordered();
		fp_cmp_pkg::fp_word_t pa [5] = '{32'h3f80_0000, 32'h0000_0000, 32'h4049_0fdb,
			32'hc040_0000, 32'h3f00_0000};
		fp_cmp_pkg::fp_word_t pb [5] = '{32'h3f80_0000, 32'h8000_0000, 32'hc000_0000,
			32'hc120_0000, 32'h4480_0000};	// Equal, zeros, signs, negatives, exponents
		for (int p = 0; p < 5; p++)
			for (int op = 0; op < 8; op++)
				cmp_and_check($sformatf("ordered pair%0d", p), fp_cmp_pkg::cmp_op_t'(op),
					pa[p], pb[p]);
	endtask

	task automatic test_unordered();
		for (int op = 0; op < 8; op++) begin
			cmp_and_check("nan in A", fp_cmp_pkg::cmp_op_t'(op), 32'h7fc0_0000, 32'h3f80_0000);
			cmp_and_check("nan in B", fp_cmp_pkg::cmp_op_t'(op), 32'hc000_0000, 32'hffa0_0001);
		end
	endtask

	task automatic test_random();
		fp_cmp_pkg::fp_word_t a, b;
		fp_cmp_pkg::cmp_op_t  op;
		logic [2:0]           mode;
		for (int n = 0; n < 40; n++) begin
			a    = rand_bits(32);
			b    = rand_bits(32);
			op   = fp_cmp_pkg::cmp_op_t'(rand_bits(3));
			mode = 3'(rand_bits(3));
			if (mode == 3'd0)
				b = a;	// Force equal
			else if (mode == 3'd1)
				b = a ^ 32'h8000_0000;	// Force opposite sign
			cmp_and_check($sformatf("random%0d", n), op, a, b);
		end
	endtask

	task automatic test_backpressure();
		fp_cmp_pkg::fp_word_t   va [6] = '{32'h3f00_0000, 32'h3f80_0000, 32'h4000_0000,
			32'hbf80_0000, 32'h3f80_0000, 32'h4000_0000};
		logic [1:0]             want [$];	// {result, nanx} in issue order
		logic [1:0]             resp;
		fp_cmp_pkg::axil_data_t data;
		axil_write(fp_cmp_pkg::ADDR_B, 32'h3f80_0000, resp);
		for (int k = 0; k < 6; k++) begin
			axil_write(fp_cmp_pkg::ADDR_A, va[k], resp);
			axil_write(fp_cmp_pkg::ADDR_CMD, 32'(k), resp);
			check($sformatf("backpressure cmd%0d resp", k),
				(k < 5) ? fp_cmp_pkg::RESP_OKAY : fp_cmp_pkg::RESP_SLVERR, resp);
			if (k < 5)
				want.push_back(model_cmp(fp_cmp_pkg::cmp_op_t'(k), va[k], 32'h3f80_0000));
		end
		axil_read(fp_cmp_pkg::ADDR_STATUS, data, resp);
		check("backpressure STATUS", 32'h0000_000c, data);	// Full, count 4
		for (int k = 0; k < 5; k++) begin
			axil_read(fp_cmp_pkg::ADDR_RESULT, data, resp);
			check($sformatf("backpressure result%0d", k),
				{29'd0, want[k][0], want[k][1], 1'b1}, data);
		end
		axil_read(fp_cmp_pkg::ADDR_RESULT, data, resp);
		check("backpressure drained", 0, data[0]);
	endtask

	task automatic test_addr_err();
		fp_cmp_pkg::axil_data_t data;
		logic [1:0]             resp;
		axil_write(fp_cmp_pkg::ADDR_STATUS, 32'hffff_ffff, resp);
		check("write STATUS resp", fp_cmp_pkg::RESP_SLVERR, resp);
		axil_read(5'h14, data, resp);	// Past the register map
		check("unmapped read resp", fp_cmp_pkg::RESP_SLVERR, resp);
		check("unmapped read data", 0, data);
	endtask

	// ************************************************************************
	// Sequence, summary and watchdog
	// ************************************************************************
	initial begin
		int mark;
		int prop_fails;
		clk     = 1'b0;
		rst_n   = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		lfsr    = 32'h18af;
		n_pass  = 0;
		n_fail  = 0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		mark = n_fail;
		test_reset();
		finish_line("reset", mark);
		mark = n_fail;
		test_ordered();
		finish_line("ordered", mark);
		mark = n_fail;
		test_unordered();
		finish_line("unordered", mark);
		mark = n_fail;
		test_random();
		finish_line("random", mark);
		mark = n_fail;
		test_backpressure();
		finish_line("backpressure", mark);
		mark = n_fail;
		test_addr_err();
		finish_line("address errors", mark);
		prop_fails = int'(fp_cmp_top_inst.cmp_axil_regs_inst.fp_cmp_props_inst.fail_count);
		if (prop_fails != 0) begin
			$display("ERROR: %0d AXI response channel assertions failed", prop_fails);
			n_fail += prop_fails;
		end
		$display("Checks passed: %0d, checks failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(TEST_LEN * 200 * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d clock cycles", TEST_LEN * 200);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* list.f */
src/fp_cmp_pkg.sv
src/fp_decomp.sv
src/fp_cmp_unit.sv
src/cmp_axil_regs.sv
src/cmp_req_fifo.sv
src/cmp_exec.sv
src/fp_cmp_top.sv
testbench/fp_cmp_props.sv
testbench/fp_cmp_tb.sv

/* Bender.yml */
package:
  name: fp_cmp

sources:
  - src/fp_cmp_pkg.sv
  - src/fp_decomp.sv
  - src/fp_cmp_unit.sv
  - src/cmp_axil_regs.sv
  - src/cmp_req_fifo.sv
  - src/cmp_exec.sv
  - src/fp_cmp_top.sv
  - target: test
    files:
      - testbench/fp_cmp_props.sv
      - testbench/fp_cmp_tb.sv
